/* Makefile */
VERILATOR ?= verilator
TOP       ?= dcache_tb
LINT_TOP  ?= dcache_top
FILELIST  ?= dcache_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* dcache_top.f */
rtl/dcache_pkg.sv
rtl/dcache_tag_array.sv
rtl/dcache_data_array.sv
rtl/dcache_byte_lane.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
dv/dcache_asserts.sv
dv/dcache_tb.sv

/* dv/dcache_asserts.sv */
`timescale 1ns/1ps
module dcache_asserts
  import dcache_pkg::*;
(
  input logic  clock,
  input logic  reset,
  input logic  req_ready,
  input logic  rsp_valid,
  input logic  rsp_ready,
  input word_t rsp_rdata,
  input logic  mem_req_valid,
  input logic  mem_req_ready,
  input logic  mem_req_write,
  input addr_t mem_req_addr,
  input word_t mem_req_wdata
);

  logic rsp_hold_failed = 1'b0;
  logic req_block_failed = 1'b0;
  logic mem_hold_failed = 1'b0;
  logic any_failed;

  assign any_failed = rsp_hold_failed || req_block_failed || mem_hold_failed;

  // Response held until the load/store unit takes it
  rsp_hold: assert property (@(posedge clock) disable iff (reset)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata))
    else begin
      rsp_hold_failed = 1'b1;
      $error("rsp_valid or rsp_rdata changed before rsp_ready");
    end

  // Next request only once the pending response is taken
  req_block: assert property (@(posedge clock) disable iff (reset)
    $rose(req_ready) |-> $past(rsp_valid && rsp_ready))
    else begin
      req_block_failed = 1'b1;
      $error("req_ready rose while no response was taken");
    end

  mem_hold: assert property (@(posedge clock) disable iff (reset)
    mem_req_valid && !mem_req_ready |=>
      mem_req_valid && $stable(mem_req_write) && $stable(mem_req_addr) &&
      $stable(mem_req_wdata))
    else begin
      mem_hold_failed = 1'b1;
      $error("memory request changed before mem_req_ready");
    end

endmodule

bind dcache_ctrl dcache_asserts u_asserts (
  .clock        (clock),
  .reset        (reset),
  .req_ready    (req_ready),
  .rsp_valid    (rsp_valid),
  .rsp_ready    (rsp_ready),
  .rsp_rdata    (rsp_rdata),
  .mem_req_valid(mem_req_valid),
  .mem_req_ready(mem_req_ready),
  .mem_req_write(mem_req_write),
  .mem_req_addr (mem_req_addr),
  .mem_req_wdata(mem_req_wdata)
);

/* dv/dcache_tb.sv */
`timescale 1ns/1ps
module dcache_tb
  import dcache_pkg::*;
();

  localparam int INDEX_BITS = 6;
  localparam int SETS = 1 << INDEX_BITS;
  localparam int N_REQS = 36;  // Requests over all tests
  localparam int CLK_PERIOD = 10;

  typedef logic [29-INDEX_BITS:0] tag_t;

  logic    clock = 1'b0;
  logic    reset;
  logic    req_valid;
  logic    req_ready;
  logic    req_write;
  addr_t   req_addr;
  access_t req_access;
  word_t   req_wdata;
  logic    rsp_valid;
  logic    rsp_ready;
  word_t   rsp_rdata;
  logic    mem_req_valid;
  logic    mem_req_ready = 1'b0;
  logic    mem_req_write;
  addr_t   mem_req_addr;
  word_t   mem_req_wdata;
  logic    mem_rsp_valid = 1'b0;
  word_t   mem_rsp_rdata = '0;

  word_t backing [addr_t];
  logic  log_write [$];
  addr_t log_addr [$];
  word_t log_data [$];

  // Reference cache state
  tag_t  m_tag [SETS][2];
  logic  m_valid [SETS][2];
  logic  m_dirty [SETS][2];
  logic  m_lru [SETS];
  word_t m_data [SETS][2];
  logic  exp_write [$];
  addr_t exp_addr [$];
  word_t exp_data [$];

  always #(CLK_PERIOD / 2) clock = ~clock;

  dcache_top #(.INDEX_BITS(INDEX_BITS)) u_dut (
    .clock        (clock),
    .reset        (reset),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .req_write    (req_write),
    .req_addr     (req_addr),
    .req_access   (req_access),
    .req_wdata    (req_wdata),
    .rsp_valid    (rsp_valid),
    .rsp_ready    (rsp_ready),
    .rsp_rdata    (rsp_rdata),
    .mem_req_valid(mem_req_valid),
    .mem_req_ready(mem_req_ready),
    .mem_req_write(mem_req_write),
    .mem_req_addr (mem_req_addr),
    .mem_req_wdata(mem_req_wdata),
    .mem_rsp_valid(mem_rsp_valid),
    .mem_rsp_rdata(mem_rsp_rdata)
  );

  task automatic stop_on_error();
    $display("CHECKS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_failure(string what);
    $display("Error at %0t: %s", $time, what);
    stop_on_error();
  endtask

  task automatic compare_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic compare_addr(string name, addr_t got, addr_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic compare_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  function automatic word_t fill_pattern(addr_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic word_t mem_read(addr_t a);
    return backing.exists(a) ? backing[a] : fill_pattern(a);
  endfunction

  function automatic word_t expect_load(word_t w, logic [1:0] off, access_t acc);
    logic [7:0]  b;
    logic [15:0] h;
    b = 8'(w >> (8 * off));
    h = 16'(w >> (off[1] ? 16 : 0));
    case (acc)
      ACC_B:   return 32'($signed(b));
      ACC_BU:  return {24'h0, b};
      ACC_H:   return 32'($signed(h));
      ACC_HU:  return {16'h0, h};
      default: return w;
    endcase
  endfunction

  function automatic word_t expect_merge(word_t w, logic [1:0] off, access_t acc, word_t sd);
    word_t mask;
    int    sh;
    case (acc)
      ACC_B: begin
        sh = 8 * off;
        mask = 32'hff << sh;
      end
      ACC_H: begin
        sh = off[1] ? 16 : 0;
        mask = 32'hffff << sh;
      end
      default: begin
        sh = 0;
        mask = '1;
      end
    endcase
    return (w & ~mask) | ((sd << sh) & mask);
  endfunction

  // One request in the reference cache, with the memory traffic it should cause
  task automatic model_access(input logic wr, input addr_t a, input access_t acc,
                              input word_t wd, output word_t rdata, output logic hit);
    int    idx;
    tag_t  tag;
    logic  way;
    word_t line;
    idx = int'(a[2 +: INDEX_BITS]);
    tag = a[31:INDEX_BITS+2];
    hit = 1'b0;
    way = 1'b0;
    for (int w = 0; w < 2; w++) begin
      if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
        hit = 1'b1;
        way = w[0];
      end
    end
    if (!hit) begin
      way = !m_valid[idx][0] ? 1'b0 : !m_valid[idx][1] ? 1'b1 : m_lru[idx];
      if (m_valid[idx][way] && m_dirty[idx][way]) begin
        exp_write.push_back(1'b1);
        exp_addr.push_back({m_tag[idx][way], a[2 +: INDEX_BITS], 2'b00});
        exp_data.push_back(m_data[idx][way]);
      end
      exp_write.push_back(1'b0);
      exp_addr.push_back({a[31:2], 2'b00});
      exp_data.push_back(32'h0);
      m_data[idx][way] = mem_read({a[31:2], 2'b00});
      m_tag[idx][way] = tag;
      m_valid[idx][way] = 1'b1;
      m_dirty[idx][way] = 1'b0;
    end
    line = m_data[idx][way];
    if (wr) begin
      m_data[idx][way] = expect_merge(line, a[1:0], acc, wd);
      m_dirty[idx][way] = 1'b1;
    end
    m_lru[idx] = ~way;
    rdata = wr ? 32'h0 : expect_load(line, a[1:0], acc);
  endtask

  // Single outstanding request, random ready and response delays
  always begin : memory_model
    logic  wr;
    addr_t a;
    word_t wd;
    word_t rd;
    @(negedge clock);
    if (mem_req_valid && !reset) begin
      wr = mem_req_write;
      a = mem_req_addr;
      wd = mem_req_wdata;
      repeat ($urandom_range(3, 0)) @(posedge clock);
      @(posedge clock);
      mem_req_ready <= 1'b1;
      @(posedge clock);  // Accepted here
      mem_req_ready <= 1'b0;
      log_write.push_back(wr);
      log_addr.push_back(a);
      log_data.push_back(wd);
      rd = 32'h0;
      if (wr) backing[a] = wd;
      else rd = mem_read(a);
      repeat ($urandom_range(3, 0) + 1) begin
        @(negedge clock);
        if (mem_req_valid) report_failure("memory request issued before the previous response");
        @(posedge clock);
      end
      mem_rsp_valid <= 1'b1;
      mem_rsp_rdata <= rd;
      @(posedge clock);
      mem_rsp_valid <= 1'b0;
    end
  end

  task automatic issue_request(input logic wr, input addr_t a, input access_t acc,
                               input word_t wd, input int stall);
    word_t exp_rdata;
    logic  hit;
    int    cycles;
    exp_write.delete();
    exp_addr.delete();
    exp_data.delete();
    log_write.delete();
    log_addr.delete();
    log_data.delete();
    model_access(wr, a, acc, wd, exp_rdata, hit);
    @(posedge clock);
    req_valid  <= 1'b1;
    req_write  <= wr;
    req_addr   <= a;
    req_access <= acc;
    req_wdata  <= wd;
    @(negedge clock);
    while (!req_ready) @(negedge clock);
    @(posedge clock);  // Acceptance edge
    req_valid <= 1'b0;
    cycles = 1;
    @(negedge clock);
    while (!rsp_valid) begin
      cycles++;
      @(negedge clock);
    end
    if (hit) check_count("hit latency in cycles", cycles, 2);
    compare_word("rsp_rdata", rsp_rdata, exp_rdata);
    repeat (stall) begin
      @(negedge clock);
      if (!rsp_valid) report_failure("rsp_valid dropped while rsp_ready was low");
      compare_word("rsp_rdata", rsp_rdata, exp_rdata);
    end
    @(posedge clock);
    rsp_ready <= 1'b1;
    @(posedge clock);
    rsp_ready <= 1'b0;
    check_count("memory requests", log_addr.size(), exp_addr.size());
    foreach (exp_addr[i]) begin
      compare_bit("mem_req_write", log_write[i], exp_write[i]);
      compare_addr("mem_req_addr", log_addr[i], exp_addr[i]);
      if (exp_write[i]) compare_word("mem_req_wdata", log_data[i], exp_data[i]);
    end
  endtask

  task automatic test_read_miss_hit();
    issue_request(1'b0, 32'h0000_0440, ACC_W, 32'h0, 0);
    issue_request(1'b0, 32'h0000_0440, ACC_W, 32'h0, 0);
  endtask

  task automatic test_load_extract();
    addr_t base;
    base = 32'h0000_0884;
    issue_request(1'b1, base, ACC_W, 32'h7f80_c201, 0);  // Mixed sign bits
    issue_request(1'b0, base, ACC_W, 32'h0, 0);
    for (int off = 0; off < 4; off++) begin
      issue_request(1'b0, base + off, ACC_B, 32'h0, 0);
      issue_request(1'b0, base + off, ACC_BU, 32'h0, 0);
    end
    for (int off = 0; off < 4; off += 2) begin
      issue_request(1'b0, base + off, ACC_H, 32'h0, 0);
      issue_request(1'b0, base + off, ACC_HU, 32'h0, 0);
    end
  endtask

  task automatic test_store_merge();
    addr_t a;
    a = 32'h0000_0c48;
    issue_request(1'b0, a, ACC_W, 32'h0, 0);
    issue_request(1'b1, a + 1, ACC_B, 32'h0000_00a5, 0);
    issue_request(1'b1, a + 2, ACC_H, 32'h0000_3c96, 0);
    issue_request(1'b0, a, ACC_W, 32'h0, 0);
    issue_request(1'b1, a, ACC_W, 32'h1234_5678, 0);
    issue_request(1'b0, a, ACC_W, 32'h0, 0);
  endtask

  // Three tags in set 5
  task automatic test_eviction();
    issue_request(1'b1, 32'h0001_0014, ACC_W, 32'hdead_beef, 0);
    issue_request(1'b0, 32'h0002_0014, ACC_W, 32'h0, 0);
    issue_request(1'b0, 32'h0003_0016, ACC_HU, 32'h0, 0);  // Dirty way 0 goes out
    issue_request(1'b0, 32'h0001_0014, ACC_W, 32'h0, 0);
  endtask

  task automatic test_store_miss();
    issue_request(1'b1, 32'h0000_0a3d, ACC_B, 32'h0000_0033, 0);
    issue_request(1'b0, 32'h0000_0a3c, ACC_W, 32'h0, 0);
  endtask

  task automatic test_back_pressure();
    access_t codes [5];
    access_t acc;
    addr_t   a;
    logic    wr;
    codes = '{ACC_B, ACC_H, ACC_W, ACC_BU, ACC_HU};
    for (int i = 0; i < 8; i++) begin
      wr = 1'($urandom_range(1, 0));
      acc = codes[$urandom_range(wr ? 2 : 4, 0)];
      a = {22'h0, 2'($urandom_range(3, 1)), 6'd40, 2'($urandom_range(3, 0))};
      if (acc inside {ACC_H, ACC_HU}) a[0] = 1'b0;
      if (acc == ACC_W) a[1:0] = 2'b00;
      issue_request(wr, a, acc, $urandom, $urandom_range(7, 0));
    end
  endtask

  initial begin
    #(N_REQS * 40 * CLK_PERIOD);
    $display("Error: no verdict after %0d cycles", N_REQS * 40);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(32'ha65edc2e));
    reset = 1'b1;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr = '0;
    req_access = ACC_W;
    req_wdata = '0;
    rsp_ready = 1'b0;
    foreach (m_valid[s, w]) begin
      m_valid[s][w] = 1'b0;
      m_dirty[s][w] = 1'b0;
    end
    foreach (m_lru[s]) m_lru[s] = 1'b0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    test_read_miss_hit();
    test_load_extract();
    test_store_merge();
    test_eviction();
    test_store_miss();
    test_back_pressure();
    repeat (2) @(posedge clock);
    if (!u_dut.u_ctrl.u_asserts.any_failed) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* rtl/dcache_byte_lane.sv */
`timescale 1ns/1ps
module dcache_byte_lane
  import dcache_pkg::*;
(
  input  word_t                  line_word,
  input  logic [OFFSET_BITS-1:0] byte_offset,
  input  access_t                access,
  input  word_t                  store_data,
  output word_t                  load_data,
  output word_t                  merged_data
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  // Halves use the aligned lane only
  assign byte_sel = line_word[{byte_offset, 3'b000} +: 8];
  assign half_sel = line_word[{byte_offset[1], 4'b0000} +: 16];

  always_comb begin
    case (access)
      ACC_B:   load_data = {{24{byte_sel[7]}}, byte_sel};
      ACC_BU:  load_data = {24'b0, byte_sel};
      ACC_H:   load_data = {{16{half_sel[15]}}, half_sel};
      ACC_HU:  load_data = {16'b0, half_sel};
      default: load_data = line_word;
    endcase
  end

  // Store merge, untouched lanes keep the line value
  always_comb begin
    merged_data = line_word;
    case (access)
      ACC_B, ACC_BU: begin
        merged_data[{byte_offset, 3'b000} +: 8] = store_data[7:0];
      end
      ACC_H, ACC_HU: begin
        merged_data[{byte_offset[1], 4'b0000} +: 16] = store_data[15:0];
      end
      default: begin
        merged_data = store_data;
      end
    endcase
  end

endmodule

/* rtl/dcache_ctrl.sv */
`timescale 1ns/1ps
module dcache_ctrl
  import dcache_pkg::*;
#(
  parameter int INDEX_BITS = 6,
  localparam int TAG_BITS = 30 - INDEX_BITS
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  req_valid,
  input  logic                  req_write,
  input  addr_t                 req_addr,
  input  access_t               req_access,
  input  word_t                 req_wdata,
  input  logic                  rsp_ready,
  input  logic                  mem_req_ready,
  input  logic                  mem_rsp_valid,
  input  word_t                 mem_rsp_rdata,
  input  logic                  hit,
  input  logic                  hit_way,
  input  logic                  victim_way,
  input  logic                  victim_dirty,
  input  logic [TAG_BITS-1:0]   victim_tag,
  input  word_t                 way_rdata,
  input  word_t                 load_data,
  input  word_t                 merged_data,
  output logic                  req_ready,
  output logic                  rsp_valid,
  output word_t                 rsp_rdata,
  output logic                  mem_req_valid,
  output logic                  mem_req_write,
  output addr_t                 mem_req_addr,
  output word_t                 mem_req_wdata,
  output logic [INDEX_BITS-1:0] lookup_index,
  output logic [TAG_BITS-1:0]   lookup_tag,
  output logic                  tag_update,
  output logic                  tag_way,
  output logic                  tag_dirty,
  output logic                  data_we,
  output logic                  data_way,
  output word_t                 data_wdata,
  output addr_t                 cur_addr,
  output access_t               cur_access,
  output word_t                 cur_wdata,
  output word_t                 fill_word
);

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  logic        cur_write;
  logic        miss_way;    // Victim way held for the whole miss
  word_t       rsp_data_q;
  logic        lookup_hit;
  logic        refill_done;

  assign req_ready = (state_q == ST_IDLE);
  assign rsp_valid = (state_q == ST_RESP);
  assign rsp_rdata = rsp_data_q;

  assign lookup_index = cur_addr[OFFSET_BITS +: INDEX_BITS];
  assign lookup_tag   = cur_addr[OFFSET_BITS + INDEX_BITS +: TAG_BITS];

  // Arrays are untouched during a miss, so victim fields stay stable
  assign mem_req_valid = (state_q == ST_WB) || (state_q == ST_FILL);
  assign mem_req_write = (state_q == ST_WB);
  assign mem_req_addr  = mem_req_write ? {victim_tag, lookup_index, {OFFSET_BITS{1'b0}}}
                                       : {cur_addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
  assign mem_req_wdata = way_rdata;

  assign fill_word   = mem_rsp_rdata;
  assign lookup_hit  = (state_q == ST_LOOKUP) && hit;
  assign refill_done = (state_q == ST_FILL_WAIT) && mem_rsp_valid;

  assign data_way   = (state_q == ST_LOOKUP) ? hit_way : miss_way;
  assign data_we    = (lookup_hit && cur_write) || refill_done;
  assign data_wdata = cur_write ? merged_data : fill_word;

  // Load hits refresh recency too
  assign tag_update = lookup_hit || refill_done;
  assign tag_way    = data_way;
  assign tag_dirty  = cur_write;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:      if (req_valid) state_d = ST_LOOKUP;
      ST_LOOKUP: begin
        if (hit) begin
          state_d = ST_RESP;
        end else if (victim_dirty) begin
          state_d = ST_WB;
        end else begin
          state_d = ST_FILL;
        end
      end
      ST_WB:        if (mem_req_ready) state_d = ST_WB_WAIT;
      ST_WB_WAIT:   if (mem_rsp_valid) state_d = ST_FILL;  // Refill only after the ack
      ST_FILL:      if (mem_req_ready) state_d = ST_FILL_WAIT;
      ST_FILL_WAIT: if (mem_rsp_valid) state_d = ST_RESP;
      ST_RESP:      if (rsp_ready) state_d = ST_IDLE;
      default:      state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q  <= ST_IDLE;
      miss_way <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_LOOKUP) miss_way <= victim_way;
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid && req_ready) begin
      cur_addr   <= req_addr;
      cur_access <= req_access;
      cur_wdata  <= req_wdata;
      cur_write  <= req_write;
    end
    if (lookup_hit || refill_done) begin
      rsp_data_q <= cur_write ? '0 : load_data;  // Stores answer with zero
    end
  end

endmodule

/* rtl/dcache_data_array.sv */
`timescale 1ns/1ps
module dcache_data_array
  import dcache_pkg::*;
#(
  parameter int INDEX_BITS = 6,
  localparam int SETS = 1 << INDEX_BITS
) (
  input  logic                  clock,
  input  logic [INDEX_BITS-1:0] lookup_index,
  input  logic                  data_we,
  input  logic                  data_way,
  input  word_t                 data_wdata,
  output word_t                 way0_rdata,
  output word_t                 way1_rdata
);

  word_t mem_q [2][SETS];

  // Both ways read in parallel
  assign way0_rdata = mem_q[0][lookup_index];
  assign way1_rdata = mem_q[1][lookup_index];

  always_ff @(posedge clock) begin
    if (data_we) begin
      mem_q[data_way][lookup_index] <= data_wdata;
    end
  end

endmodule

/* rtl/dcache_pkg.sv */
package dcache_pkg;

  // Byte offset within a 32-bit block
  localparam int OFFSET_BITS = 2;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // Load/store size and extension code
  typedef enum logic [2:0] {
    ACC_B  = 3'd0, // signed byte
    ACC_H  = 3'd1, // signed half
    ACC_W  = 3'd2,
    ACC_BU = 3'd4,
    ACC_HU = 3'd5
  } access_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_WB,        // Victim write request
    ST_WB_WAIT,   // Waiting for write ack
    ST_FILL,      // Refill read request
    ST_FILL_WAIT,
    ST_RESP
  } ctrl_state_t;

endpackage

/* rtl/dcache_tag_array.sv */
`timescale 1ns/1ps
module dcache_tag_array #(
  parameter int INDEX_BITS = 6,
  localparam int SETS = 1 << INDEX_BITS,
  localparam int TAG_BITS = 30 - INDEX_BITS
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [INDEX_BITS-1:0] lookup_index,
  input  logic [TAG_BITS-1:0]   lookup_tag,
  input  logic                  tag_update,
  input  logic                  tag_way,
  input  logic                  tag_dirty,
  output logic                  hit,
  output logic                  hit_way,
  output logic                  victim_way,
  output logic                  victim_dirty,
  output logic [TAG_BITS-1:0]   victim_tag
);

  logic [TAG_BITS-1:0]    tags_q [SETS][2];
  logic [SETS-1:0][1:0]   valid_q;
  logic [SETS-1:0][1:0]   dirty_q;
  logic [SETS-1:0]        lru_q;   // Names the least recently used way
  logic                   hit0;
  logic                   hit1;
  logic                   keep_dirty;

  assign hit0 = valid_q[lookup_index][0] && (tags_q[lookup_index][0] == lookup_tag);
  assign hit1 = valid_q[lookup_index][1] && (tags_q[lookup_index][1] == lookup_tag);

  assign hit     = hit0 || hit1;
  assign hit_way = hit1;

  // Empty way first, way 0 before way 1
  assign victim_way = !valid_q[lookup_index][0] ? 1'b0 :
                      !valid_q[lookup_index][1] ? 1'b1 : lru_q[lookup_index];

  assign victim_dirty = valid_q[lookup_index][victim_way] && dirty_q[lookup_index][victim_way];
  assign victim_tag   = tags_q[lookup_index][victim_way];

  // A hit on the updated way keeps its dirty state, a refill replaces it
  assign keep_dirty = hit && (hit_way == tag_way) && dirty_q[lookup_index][tag_way];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;
    end else if (tag_update) begin
      valid_q[lookup_index][tag_way] <= 1'b1;
      dirty_q[lookup_index][tag_way] <= tag_dirty || keep_dirty;
      lru_q[lookup_index]            <= ~tag_way;
    end
  end

  always_ff @(posedge clock) begin
    if (tag_update) begin
      tags_q[lookup_index][tag_way] <= lookup_tag;
    end
  end

endmodule

/* rtl/dcache_top.sv */
`timescale 1ns/1ps
module dcache_top
  import dcache_pkg::*;
#(
  parameter int INDEX_BITS = 6,
  localparam int TAG_BITS = 30 - INDEX_BITS
) (
  input  logic    clock,
  input  logic    reset,
  input  logic    req_valid,
  output logic    req_ready,
  input  logic    req_write,
  input  addr_t   req_addr,
  input  access_t req_access,
  input  word_t   req_wdata,
  output logic    rsp_valid,
  input  logic    rsp_ready,
  output word_t   rsp_rdata,
  output logic    mem_req_valid,
  input  logic    mem_req_ready,
  output logic    mem_req_write,
  output addr_t   mem_req_addr,
  output word_t   mem_req_wdata,
  input  logic    mem_rsp_valid,
  input  word_t   mem_rsp_rdata
);

  logic [INDEX_BITS-1:0] lookup_index;
  logic [TAG_BITS-1:0]   lookup_tag;
  logic [TAG_BITS-1:0]   victim_tag;
  logic                  hit;
  logic                  hit_way;
  logic                  victim_way;
  logic                  victim_dirty;
  logic                  tag_update;
  logic                  tag_way;
  logic                  tag_dirty;
  logic                  data_we;
  logic                  data_way;
  word_t                 data_wdata;
  word_t                 way0_rdata;
  word_t                 way1_rdata;
  word_t                 way_rdata;
  word_t                 line_word;
  word_t                 load_data;
  word_t                 merged_data;
  word_t                 fill_word;
  addr_t                 cur_addr;
  access_t               cur_access;
  word_t                 cur_wdata;

  // data_way follows hit_way during lookup and the victim during a miss
  assign way_rdata = data_way ? way1_rdata : way0_rdata;
  assign line_word = hit ? way_rdata : fill_word;

  dcache_ctrl #(.INDEX_BITS(INDEX_BITS)) u_ctrl (
    .clock        (clock),
    .reset        (reset),
    .req_valid    (req_valid),
    .req_write    (req_write),
    .req_addr     (req_addr),
    .req_access   (req_access),
    .req_wdata    (req_wdata),
    .rsp_ready    (rsp_ready),
    .mem_req_ready(mem_req_ready),
    .mem_rsp_valid(mem_rsp_valid),
    .mem_rsp_rdata(mem_rsp_rdata),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .way_rdata    (way_rdata),
    .load_data    (load_data),
    .merged_data  (merged_data),
    .req_ready    (req_ready),
    .rsp_valid    (rsp_valid),
    .rsp_rdata    (rsp_rdata),
    .mem_req_valid(mem_req_valid),
    .mem_req_write(mem_req_write),
    .mem_req_addr (mem_req_addr),
    .mem_req_wdata(mem_req_wdata),
    .lookup_index (lookup_index),
    .lookup_tag   (lookup_tag),
    .tag_update   (tag_update),
    .tag_way      (tag_way),
    .tag_dirty    (tag_dirty),
    .data_we      (data_we),
    .data_way     (data_way),
    .data_wdata   (data_wdata),
    .cur_addr     (cur_addr),
    .cur_access   (cur_access),
    .cur_wdata    (cur_wdata),
    .fill_word    (fill_word)
  );

  dcache_tag_array #(.INDEX_BITS(INDEX_BITS)) u_tag_array (
    .clock       (clock),
    .reset       (reset),
    .lookup_index(lookup_index),
    .lookup_tag  (lookup_tag),
    .tag_update  (tag_update),
    .tag_way     (tag_way),
    .tag_dirty   (tag_dirty),
    .hit         (hit),
    .hit_way     (hit_way),
    .victim_way  (victim_way),
    .victim_dirty(victim_dirty),
    .victim_tag  (victim_tag)
  );

  dcache_data_array #(.INDEX_BITS(INDEX_BITS)) u_data_array (
    .clock       (clock),
    .lookup_index(lookup_index),
    .data_we     (data_we),
    .data_way    (data_way),
    .data_wdata  (data_wdata),
    .way0_rdata  (way0_rdata),
    .way1_rdata  (way1_rdata)
  );

  dcache_byte_lane u_byte_lane (
    .line_word  (line_word),
    .byte_offset(cur_addr[OFFSET_BITS-1:0]),
    .access     (cur_access),
    .store_data (cur_wdata),
    .load_data  (load_data),
    .merged_data(merged_data)
  );

endmodule
